//--- is_settings.svh
////////////////////
// issue stage sizing
// queue depth, tag width and port counts
////////////////////

`ifndef IS_SETTINGS_SVH
`define IS_SETTINGS_SVH

// issue queue
`define ISQ_DEPTH 16
`define ISQ_IDX_W 4

// physical register tag
`define PREG_W 6

// instructions from allocation per cycle
`define DISP_PORTS 2

// ready broadcasts from execution per cycle
`define WAKE_PORTS 4

// mul, alu 1, alu 2, adr
`define ISS_PORTS 4

`endif

//--- is_pkg.sv
////////////////////
// issue stage types
// instruction, wakeup and issue port formats
////////////////////

`include "is_settings.svh"

package is_pkg;

   // function unit kind of an instruction
   typedef enum logic [1:0]
   {
      MUL = 2'd0,
      ALU = 2'd1,
      ADR = 2'd2
   } is_fu_e;

   // second operand, register tag or immediate depending on use_imm
   typedef union packed
   {
      struct packed
      {
         logic [1:0]         pad;
         logic [`PREG_W-1:0] tag;
      } src;
      logic [7:0] imm;
   } is_op2_u;

   // renamed instruction from allocation
   typedef struct packed
   {
      logic               vld;
      is_fu_e             fu;
      logic               use_imm;
      logic [`PREG_W-1:0] src1;
      is_op2_u            op2;
      logic [`PREG_W-1:0] dest;
      logic [5:0]         opc;
   } is_inst_t;

   // tag that just became ready
   typedef struct packed
   {
      logic               vld;
      logic [`PREG_W-1:0] tag;
   } is_wake_t;

   // one issue port towards register read
   typedef struct packed
   {
      logic                  vld;
      logic [`ISQ_IDX_W-1:0] idx;
      is_inst_t              inst;
   } is_iss_t;

endpackage

//--- isq_alloc.sv
////////////////////
// issue queue allocation
// lowest two free slots and the full flag
////////////////////

`include "is_settings.svh"

module isq_alloc
   import is_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_i,
   input  is_inst_t              inst_i [`DISP_PORTS],
   input  logic [`ISQ_DEPTH-1:0] occ_i,
   output logic [`ISQ_DEPTH-1:0] lin_en_o,
   output logic [`ISQ_IDX_W-1:0] slot_o [`DISP_PORTS],
   output logic                  ful_o
);

   localparam int CNT_W = `ISQ_IDX_W + 1;

   logic [`ISQ_IDX_W-1:0]  f0;
   logic [`ISQ_IDX_W-1:0]  f1;
   logic                   found0;
   logic                   found1;
   logic [`DISP_PORTS-1:0] acc;
   logic [CNT_W-1:0]       free_q;

   // scan upwards, first hit is f0, second is f1
   always_comb
   begin
      f0     = '0;
      f1     = '0;
      found0 = 1'b0;
      found1 = 1'b0;
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         if (!occ_i[i])
         begin
            if (!found0)
            begin
               f0     = `ISQ_IDX_W'(i);
               found0 = 1'b1;
            end
            else if (!found1)
            begin
               f1     = `ISQ_IDX_W'(i);
               found1 = 1'b1;
            end
         end
      end
   end

   // invalid port 0 leaves the lowest slot to port 1
   assign slot_o[0] = f0;
   assign slot_o[1] = inst_i[0].vld ? f1 : f0;

   assign acc[0] = inst_i[0].vld & ~ful_o;
   assign acc[1] = inst_i[1].vld & ~ful_o;

   assign lin_en_o = (acc[0] ? (`ISQ_DEPTH'(1) << slot_o[0]) : '0) |
                     (acc[1] ? (`ISQ_DEPTH'(1) << slot_o[1]) : '0);

   // free count after this edge's writes
   // same-edge grants show up a cycle late, so it only undercounts
   always_ff @(posedge clk)
   begin
      if (rst_i)
         free_q <= CNT_W'(`ISQ_DEPTH);
      else
         free_q <= CNT_W'($countones(~(occ_i | lin_en_o)));
   end

   assign ful_o = free_q < CNT_W'(2);

   a_two_slots : assert property (@(posedge clk) disable iff (rst_i)
      (&acc) |-> (slot_o[0] != slot_o[1]) && ($countones(lin_en_o) == 2));

endmodule

//--- isq.sv
////////////////////
// issue queue storage
// holds dispatched entries and their occupied bits
////////////////////

`include "is_settings.svh"

module isq
   import is_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_i,
   input  is_inst_t              inst_i [`DISP_PORTS],
   input  logic [`ISQ_DEPTH-1:0] lin_en_i,
   input  logic [`ISQ_IDX_W-1:0] slot_i [`DISP_PORTS],
   input  logic [`ISQ_DEPTH-1:0] clr_i,
   input  logic                  fls_i,
   output is_inst_t              ent_o  [`ISQ_DEPTH],
   output logic [`ISQ_DEPTH-1:0] occ_o
);

   is_inst_t              ent_q [`ISQ_DEPTH];
   is_inst_t              din   [`ISQ_DEPTH];
   logic [`ISQ_DEPTH-1:0] occ_q;

   ////////////////////
   // write data per slot
   ////////////////////

   // port 1 owns a slot only when it is valid and points there
   always_comb
   begin
      for (int e = 0; e < `ISQ_DEPTH; e++)
      begin
         if (inst_i[1].vld && slot_i[1] == `ISQ_IDX_W'(e))
            din[e] = inst_i[1];
         else
            din[e] = inst_i[0];
      end
   end

   always_ff @(posedge clk)
   begin
      for (int e = 0; e < `ISQ_DEPTH; e++)
      begin
         if (lin_en_i[e])
            ent_q[e] <= din[e];
      end
   end

   ////////////////////
   // occupancy
   ////////////////////

   // flush wins over grants and new writes
   always_ff @(posedge clk)
   begin
      if (rst_i || fls_i)
         occ_q <= '0;
      else
         occ_q <= (occ_q & ~clr_i) | lin_en_i;
   end

   // entries look invalid once freed
   always_comb
   begin
      for (int e = 0; e < `ISQ_DEPTH; e++)
      begin
         ent_o[e]     = ent_q[e];
         ent_o[e].vld = ent_q[e].vld & occ_q[e];
      end
   end

   assign occ_o = occ_q;

   // allocation never overwrites a live entry that the arbiter keeps
   a_no_overwrite : assert property (@(posedge clk) disable iff (rst_i)
      fls_i || ((lin_en_i & occ_q & ~clr_i) == '0));

endmodule

//--- tpu.sv
////////////////////
// tag tracker
// per-entry source ready bits, set by wakeup broadcasts
////////////////////

`include "is_settings.svh"

module tpu
   import is_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_i,
   input  is_inst_t              inst_i [`DISP_PORTS],
   input  logic [`ISQ_DEPTH-1:0] lin_en_i,
   input  logic [`ISQ_IDX_W-1:0] slot_i [`DISP_PORTS],
   input  is_wake_t              wake_i [`WAKE_PORTS],
   input  logic [`ISQ_DEPTH-1:0] clr_i,
   input  logic                  fls_i,
   output logic [`ISQ_DEPTH-1:0] rdy_o
);

   is_inst_t              din    [`ISQ_DEPTH];
   logic [`PREG_W-1:0]    tag1_q [`ISQ_DEPTH];
   logic [`PREG_W-1:0]    tag2_q [`ISQ_DEPTH];
   logic [`ISQ_DEPTH-1:0] r1_q;
   logic [`ISQ_DEPTH-1:0] r2_q;
   logic [`ISQ_DEPTH-1:0] occ_q;

   // any valid broadcast carrying this tag
   function automatic logic woken(input logic [`PREG_W-1:0] tag,
                                  input is_wake_t wk [`WAKE_PORTS]);
      logic hit;
      hit = 1'b0;
      for (int w = 0; w < `WAKE_PORTS; w++)
      begin
         if (wk[w].vld && wk[w].tag == tag)
            hit = 1'b1;
      end
      return hit;
   endfunction

   // same slot steering as the queue
   always_comb
   begin
      for (int e = 0; e < `ISQ_DEPTH; e++)
      begin
         if (inst_i[1].vld && slot_i[1] == `ISQ_IDX_W'(e))
            din[e] = inst_i[1];
         else
            din[e] = inst_i[0];
      end
   end

   ////////////////////
   // ready bits
   ////////////////////

   always_ff @(posedge clk)
   begin
      for (int e = 0; e < `ISQ_DEPTH; e++)
      begin
         if (lin_en_i[e])
         begin
            tag1_q[e] <= din[e].src1;
            tag2_q[e] <= din[e].op2.src.tag;
            // broadcast in the dispatch cycle already counts
            r1_q[e]   <= woken(din[e].src1, wake_i);
            r2_q[e]   <= din[e].use_imm | woken(din[e].op2.src.tag, wake_i);
         end
         else
         begin
            r1_q[e] <= r1_q[e] | woken(tag1_q[e], wake_i);
            r2_q[e] <= r2_q[e] | woken(tag2_q[e], wake_i);
         end
      end
   end

   // local copy of queue occupancy
   always_ff @(posedge clk)
   begin
      if (rst_i || fls_i)
         occ_q <= '0;
      else
         occ_q <= (occ_q & ~clr_i) | lin_en_i;
   end

   assign rdy_o = occ_q & r1_q & r2_q;

endmodule

//--- pdc.sv
////////////////////
// select arbiter
// grants ready entries to the four issue ports
////////////////////

`include "is_settings.svh"

module pdc
   import is_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_i,
   input  is_inst_t              ent_i [`ISQ_DEPTH],
   input  logic [`ISQ_DEPTH-1:0] rdy_i,
   input  logic [`ISS_PORTS-1:0] fun_rdy_i,
   input  logic                  fls_i,
   output logic [`ISQ_DEPTH-1:0] clr_o,
   output is_iss_t               mul_o,
   output is_iss_t               alu1_o,
   output is_iss_t               alu2_o,
   output is_iss_t               adr_o
);

   // port order in fun_rdy_i
   localparam int P_MUL  = 0;
   localparam int P_ALU1 = 1;
   localparam int P_ALU2 = 2;
   localparam int P_ADR  = 3;

   logic [`ISQ_DEPTH-1:0] mul_c;
   logic [`ISQ_DEPTH-1:0] alu_c;
   logic [`ISQ_DEPTH-1:0] adr_c;
   logic [`ISQ_DEPTH-1:0] gnt [`ISS_PORTS];
   logic [`ISS_PORTS-1:0] gnt_any;
   is_iss_t               iss_q [`ISS_PORTS];

   // isolate lowest set bit
   function automatic logic [`ISQ_DEPTH-1:0] lowest(input logic [`ISQ_DEPTH-1:0] v);
      return v & (~v + `ISQ_DEPTH'(1));
   endfunction

   function automatic logic [`ISQ_IDX_W-1:0] enc(input logic [`ISQ_DEPTH-1:0] oh);
      logic [`ISQ_IDX_W-1:0] idx;
      idx = '0;
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         if (oh[i])
            idx = idx | `ISQ_IDX_W'(i);
      end
      return idx;
   endfunction

   ////////////////////
   // select
   ////////////////////

   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         mul_c[i] = rdy_i[i] && (ent_i[i].fu == MUL);
         alu_c[i] = rdy_i[i] && (ent_i[i].fu == ALU);
         adr_c[i] = rdy_i[i] && (ent_i[i].fu == ADR);
      end
      gnt[P_MUL]  = fun_rdy_i[P_MUL]  ? lowest(mul_c) : '0;
      gnt[P_ALU1] = fun_rdy_i[P_ALU1] ? lowest(alu_c) : '0;
      // second alu takes whatever alu 1 left behind
      gnt[P_ALU2] = fun_rdy_i[P_ALU2] ? lowest(alu_c & ~gnt[P_ALU1]) : '0;
      gnt[P_ADR]  = fun_rdy_i[P_ADR]  ? lowest(adr_c) : '0;
      for (int p = 0; p < `ISS_PORTS; p++)
         gnt_any[p] = |gnt[p];
      clr_o = gnt[P_MUL] | gnt[P_ALU1] | gnt[P_ALU2] | gnt[P_ADR];
   end

   ////////////////////
   // issue registers
   ////////////////////

   always_ff @(posedge clk)
   begin
      for (int p = 0; p < `ISS_PORTS; p++)
      begin
         if (rst_i || fls_i)
            iss_q[p].vld <= 1'b0;
         else
            iss_q[p].vld <= gnt_any[p];
         iss_q[p].idx  <= enc(gnt[p]);
         iss_q[p].inst <= ent_i[enc(gnt[p])];
      end
   end

   assign mul_o  = iss_q[P_MUL];
   assign alu1_o = iss_q[P_ALU1];
   assign alu2_o = iss_q[P_ALU2];
   assign adr_o  = iss_q[P_ADR];

   // one cleared entry per granting port, so no entry is shared
   a_one_port : assert property (@(posedge clk) disable iff (rst_i)
      $countones(clr_o) == $countones(gnt_any));

endmodule

//--- is.sv
////////////////////
// issue stage top
// allocation, queue, tag tracker and select arbiter
////////////////////

`include "is_settings.svh"

module is
   import is_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_i,
   input  is_inst_t              inst_i [`DISP_PORTS],
   output logic                  ful_o,
   input  is_wake_t              wake_i [`WAKE_PORTS],
   input  logic [`ISS_PORTS-1:0] fun_rdy_i,
   input  logic                  fls_i,
   output is_iss_t               mul_o,
   output is_iss_t               alu1_o,
   output is_iss_t               alu2_o,
   output is_iss_t               adr_o
);

   logic [`ISQ_DEPTH-1:0] occ;
   logic [`ISQ_DEPTH-1:0] lin_en;
   logic [`ISQ_IDX_W-1:0] slot [`DISP_PORTS];
   is_inst_t              ent  [`ISQ_DEPTH];
   logic [`ISQ_DEPTH-1:0] rdy;
   logic [`ISQ_DEPTH-1:0] clr;

   isq_alloc u_alloc (
      .clk      (clk),
      .rst_i    (rst_i),
      .inst_i   (inst_i),
      .occ_i    (occ),
      .lin_en_o (lin_en),
      .slot_o   (slot),
      .ful_o    (ful_o)
   );

   isq u_isq (
      .clk      (clk),
      .rst_i    (rst_i),
      .inst_i   (inst_i),
      .lin_en_i (lin_en),
      .slot_i   (slot),
      .clr_i    (clr),
      .fls_i    (fls_i),
      .ent_o    (ent),
      .occ_o    (occ)
   );

   tpu u_tpu (
      .clk      (clk),
      .rst_i    (rst_i),
      .inst_i   (inst_i),
      .lin_en_i (lin_en),
      .slot_i   (slot),
      .wake_i   (wake_i),
      .clr_i    (clr),
      .fls_i    (fls_i),
      .rdy_o    (rdy)
   );

   pdc u_pdc (
      .clk       (clk),
      .rst_i     (rst_i),
      .ent_i     (ent),
      .rdy_i     (rdy),
      .fun_rdy_i (fun_rdy_i),
      .fls_i     (fls_i),
      .clr_o     (clr),
      .mul_o     (mul_o),
      .alu1_o    (alu1_o),
      .alu2_o    (alu2_o),
      .adr_o     (adr_o)
   );

endmodule

//--- tb_is.sv
////////////////////
// issue stage testbench
// directed tests for dispatch, wakeup, select, full and flush
////////////////////

`include "is_settings.svh"

module tb_is
   import is_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_CYCLES = 400;

   logic                  clk = 1'b0;
   logic                  rst_i;
   is_inst_t              inst [`DISP_PORTS];
   logic                  ful;
   is_wake_t              wake [`WAKE_PORTS];
   logic [`ISS_PORTS-1:0] fun_rdy;
   logic                  fls;
   is_iss_t               mul;
   is_iss_t               alu1;
   is_iss_t               alu2;
   is_iss_t               adr;

   int       errors = 0;
   int       cycles = 0;
   integer   seed;
   is_inst_t saved [`ISQ_DEPTH];
   int       seen  [`ISQ_DEPTH];

   is u_dut (
      .clk       (clk),
      .rst_i     (rst_i),
      .inst_i    (inst),
      .ful_o     (ful),
      .wake_i    (wake),
      .fun_rdy_i (fun_rdy),
      .fls_i     (fls),
      .mul_o     (mul),
      .alu1_o    (alu1),
      .alu2_o    (alu2),
      .adr_o     (adr)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: run went past %0d cycles", MAX_CYCLES);
         $display("** FAIL **");
         $finish;
      end
   end

   ////////////////////
   // helpers
   ////////////////////

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   // random opcode and a random immediate when use_imm is set
   function automatic is_inst_t make_inst(input is_fu_e fu, input logic use_imm,
                                          input logic [`PREG_W-1:0] src1,
                                          input logic [`PREG_W-1:0] src2,
                                          input logic [`PREG_W-1:0] dest);
      is_inst_t x;
      x         = '0;
      x.vld     = 1'b1;
      x.fu      = fu;
      x.use_imm = use_imm;
      x.src1    = src1;
      if (use_imm)
         x.op2.imm = 8'($random(seed));
      else
      begin
         x.op2.src.pad = 2'b00;
         x.op2.src.tag = src2;
      end
      x.dest = dest;
      x.opc  = 6'($random(seed));
      return x;
   endfunction

   function automatic is_wake_t wake_of(input int tag);
      is_wake_t w;
      w.vld = 1'b1;
      w.tag = `PREG_W'(tag);
      return w;
   endfunction

   // mul, alu, alu, adr repeating
   function automatic is_fu_e fu_of(input int i);
      case (i % 4)
         0: return MUL;
         3: return ADR;
         default: return ALU;
      endcase
   endfunction

   task automatic idle_inputs();
      for (int d = 0; d < `DISP_PORTS; d++)
         inst[d].vld = 1'b0;
      for (int w = 0; w < `WAKE_PORTS; w++)
         wake[w].vld = 1'b0;
   endtask

   task automatic expect_idle();
      check("mul_o.vld", 64'(mul.vld), 64'd0);
      check("alu1_o.vld", 64'(alu1.vld), 64'd0);
      check("alu2_o.vld", 64'(alu2.vld), 64'd0);
      check("adr_o.vld", 64'(adr.vld), 64'd0);
   endtask

   task automatic expect_issue(input string name, input is_iss_t p, input is_inst_t e);
      check({name, ".vld"}, 64'(p.vld), 64'd1);
      check({name, ".inst"}, 64'(p.inst), 64'(e));
   endtask

   // entry i waits on tag base+i and carries dest i
   task automatic fill_queue(input int base);
      for (int p = 0; p < `ISQ_DEPTH / 2; p++)
      begin
         check("ful_o", 64'(ful), 64'd0);
         for (int d = 0; d < `DISP_PORTS; d++)
         begin
            saved[2*p+d] = make_inst(fu_of(2*p+d), 1'b1, `PREG_W'(base+2*p+d), '0,
                                     `PREG_W'(2*p+d));
            inst[d] = saved[2*p+d];
         end
         @(negedge clk);
         expect_idle();
      end
      idle_inputs();
      check("ful_o", 64'(ful), 64'd1);
   endtask

   task automatic record_issue(input string name, input is_iss_t p);
      int e;
      e = int'(p.inst.dest);
      if (p.vld)
      begin
         if (e < `ISQ_DEPTH)
         begin
            seen[e]++;
            check({name, ".inst"}, 64'(p.inst), 64'(saved[e]));
         end
         else
         begin
            errors++;
            $display("%s issued an instruction dispatched while the queue was full", name);
         end
      end
   endtask

   ////////////////////
   // tests
   ////////////////////

   task automatic test_reset();
      expect_idle();
      check("ful_o", 64'(ful), 64'd0);
   endtask

   task automatic test_ready_issue();
      is_inst_t a;
      is_inst_t b;
      is_inst_t c;
      a = make_inst(MUL, 1'b1, 6'd1, '0, 6'd40);
      b = make_inst(ADR, 1'b1, 6'd2, '0, 6'd41);
      inst[0] = a;
      inst[1] = b;
      wake[0] = wake_of(1);
      wake[1] = wake_of(2);
      @(negedge clk);
      idle_inputs();
      expect_idle();
      @(negedge clk);
      expect_issue("mul_o", mul, a);
      expect_issue("adr_o", adr, b);
      check("alu1_o.vld", 64'(alu1.vld), 64'd0);
      check("alu2_o.vld", 64'(alu2.vld), 64'd0);
      @(negedge clk);
      expect_idle();
      // register op2 with both tags woken at dispatch, only port 1 valid
      c = make_inst(MUL, 1'b0, 6'd3, 6'd4, 6'd47);
      inst[1] = c;
      wake[0] = wake_of(3);
      wake[1] = wake_of(4);
      @(negedge clk);
      idle_inputs();
      @(negedge clk);
      expect_issue("mul_o", mul, c);
      check("mul_o.idx", 64'(mul.idx), 64'd0);
      @(negedge clk);
      expect_idle();
   endtask

   task automatic test_alu_pair();
      is_inst_t a;
      is_inst_t b;
      a = make_inst(ALU, 1'b1, 6'd5, '0, 6'd42);
      b = make_inst(ALU, 1'b1, 6'd6, '0, 6'd43);
      inst[0] = a;
      inst[1] = b;
      wake[0] = wake_of(5);
      wake[1] = wake_of(6);
      @(negedge clk);
      idle_inputs();
      @(negedge clk);
      expect_issue("alu1_o", alu1, a);
      expect_issue("alu2_o", alu2, b);
      check("alu1_o.idx", 64'(alu1.idx), 64'd0);
      check("alu2_o.idx", 64'(alu2.idx), 64'd1);
      check("mul_o.vld", 64'(mul.vld), 64'd0);
      check("adr_o.vld", 64'(adr.vld), 64'd0);
      // alu 1 held off
      a = make_inst(ALU, 1'b1, 6'd7, '0, 6'd44);
      b = make_inst(ALU, 1'b1, 6'd8, '0, 6'd45);
      inst[0] = a;
      inst[1] = b;
      wake[0] = wake_of(7);
      wake[1] = wake_of(8);
      fun_rdy = 4'b1101;
      @(negedge clk);
      idle_inputs();
      @(negedge clk);
      expect_issue("alu2_o", alu2, a);
      check("alu1_o.vld", 64'(alu1.vld), 64'd0);
      fun_rdy = 4'b1111;
      @(negedge clk);
      expect_issue("alu1_o", alu1, b);
      check("alu2_o.vld", 64'(alu2.vld), 64'd0);
      @(negedge clk);
      expect_idle();
   endtask

   task automatic test_wakeup();
      is_inst_t a;
      // src2 woken at dispatch while src1 stays pending
      a = make_inst(ALU, 1'b0, 6'd10, 6'd11, 6'd46);
      inst[0] = a;
      wake[0] = wake_of(11);
      @(negedge clk);
      idle_inputs();
      repeat (4)
      begin
         @(negedge clk);
         expect_idle();
      end
      wake[0] = wake_of(10);
      @(negedge clk);
      idle_inputs();
      expect_idle();
      @(negedge clk);
      expect_issue("alu1_o", alu1, a);
      @(negedge clk);
      expect_idle();
   endtask

   task automatic test_fill_drain();
      for (int i = 0; i < `ISQ_DEPTH; i++)
         seen[i] = 0;
      fill_queue(16);
      // allocation holds this one while the queue is full
      inst[0] = make_inst(ALU, 1'b1, 6'd60, '0, 6'd63);
      wake[0] = wake_of(60);
      repeat (3)
      begin
         @(negedge clk);
         expect_idle();
         check("ful_o", 64'(ful), 64'd1);
      end
      idle_inputs();
      for (int c = 0; c < 12; c++)
      begin
         for (int w = 0; w < `WAKE_PORTS; w++)
         begin
            if (c < 4)
               wake[w] = wake_of(16 + 4*c + w);
            else
               wake[w].vld = 1'b0;
         end
         @(negedge clk);
         record_issue("mul_o", mul);
         record_issue("alu1_o", alu1);
         record_issue("alu2_o", alu2);
         record_issue("adr_o", adr);
      end
      for (int i = 0; i < `ISQ_DEPTH; i++)
         check($sformatf("issue count of entry %0d", i), 64'(seen[i]), 64'd1);
      check("ful_o", 64'(ful), 64'd0);
   endtask

   task automatic test_flush();
      fill_queue(32);
      fls = 1'b1;
      @(negedge clk);
      fls = 1'b0;
      expect_idle();
      for (int c = 0; c < 6; c++)
      begin
         for (int w = 0; w < `WAKE_PORTS; w++)
         begin
            if (c < 4)
               wake[w] = wake_of(32 + 4*c + w);
            else
               wake[w].vld = 1'b0;
         end
         @(negedge clk);
         expect_idle();
      end
      check("ful_o", 64'(ful), 64'd0);
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial
   begin
      seed    = 32'h9937cca1;
      rst_i   = 1'b1;
      fls     = 1'b0;
      fun_rdy = 4'b1111;
      for (int d = 0; d < `DISP_PORTS; d++)
         inst[d] = '0;
      for (int w = 0; w < `WAKE_PORTS; w++)
         wake[w] = '0;
      repeat (8) @(negedge clk);
      rst_i = 1'b0;

      test_reset();
      test_ready_issue();
      test_alu_pair();
      test_wakeup();
      test_fill_drain();
      test_flush();

      $display("tests done, %0d errors", errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- is.f
+incdir+.
is_pkg.sv
isq_alloc.sv
isq.sv
tpu.sv
pdc.sv
is.sv
tb_is.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_is
FLIST     ?= is.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# a crashed or aborted run also counts as failed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || echo "** FAIL **" >> $(LOG)
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
